/* project.f */
source/decode_pkg.sv
source/prefix_scan.sv
source/opcode_classify.sv
source/modrm_sib_decode.sv
source/field_align.sv
source/decode_control.sv
source/decode_stage_0.sv
verification/tb_clock_gen.sv
verification/decode_checker.sv
verification/tb_decode_stage_0.sv

/* run_sim.sh */
#!/bin/sh
# Compile the decode stage 0 testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_decode_stage_0 -f project.f \
   && ./obj_dir/Vtb_decode_stage_0 | tee /dev/stderr | grep -qx "PASS: all tests" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* source/decode_control.sv */
// Stage 0 control
// Fetch/stage handshake, output register, sticky halt and flush

`timescale 1ns/1ps

module decode_control #(
   parameter int ADDR_WIDTH = 32
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      flush,
   input  logic                      handle_int,
   output logic                      halt,
   input  logic                      f_valid,
   output logic                      f_ready,
   input  logic [5:0]                valid_bytes,
   input  decode_pkg::decoded_inst_t inst_in,
   input  logic                      is_halt,
   input  logic [ADDR_WIDTH-1:0]     f_pc,
   input  logic                      f_branch_taken,
   output logic                      s0_valid,
   input  logic                      s0_ready,
   output decode_pkg::decoded_inst_t s0_inst,
   output logic [ADDR_WIDTH-1:0]     s0_pc,
   output logic                      s0_branch_taken
);

   logic length_ok;
   logic slot_free;
   logic accept;

   // Whole instruction must sit inside the valid bytes
   assign length_ok = ({1'b0, inst_in.length} <= valid_bytes);
   // Output register drains this cycle or is already empty
   assign slot_free = !s0_valid || s0_ready;
   assign f_ready   = length_ok && !halt && slot_free && !flush;
   assign accept    = f_valid && f_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s0_valid <= 1'b0;
         halt     <= 1'b0;
      end else begin
         if (flush) begin
            s0_valid <= 1'b0;
         end else if (accept) begin
            s0_valid <= 1'b1;
         end else if (s0_ready) begin
            s0_valid <= 1'b0;
         end

         // Interrupt or flush wakes the stage
         if (flush || handle_int) begin
            halt <= 1'b0;
         end else if (accept && is_halt) begin
            halt <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         s0_inst         <= inst_in;
         s0_pc           <= f_pc;
         s0_branch_taken <= f_branch_taken;
      end
   end

   // Stalled output keeps its payload until taken
   assert property (@(posedge clk) disable iff (!rst_n)
      (s0_valid && !s0_ready && !flush) |=> (s0_valid && $stable(s0_inst)))
      else $error("decode_control: s0_inst changed under back-pressure");

endmodule

/* source/decode_pkg.sv */
// Shared types and constants for x86 decode stage 0
// Fetch window, decoded instruction record and opcode classification

package decode_pkg;

   // Opcode and prefix byte values
   localparam logic [7:0] OPC_HLT    = 8'hF4;
   localparam logic [7:0] OPC_ESCAPE = 8'h0F;
   localparam logic [7:0] PFX_OPSIZE = 8'h66;

   // Longest instruction the 32-bit subset can build
   // 3 prefixes, 2 opcode, ModRM+SIB, disp32 and imm32
   localparam int MAX_INST_LEN = 15;

   // One offer from fetch
   typedef struct packed {
      // Byte 0 sits in bits 127:120
      logic [127:0] instruction;
      // Number of valid bytes, 0 to 16
      logic [5:0]   valid_bytes;
   } fetch_window_t;

   // Stage 0 result handed to stage 1
   typedef struct packed {
      // Raw first three window bytes
      logic [23:0] prefix;
      logic [1:0]  prefix_bytes;
      logic        size_override;
      // Left-aligned, unused low byte is zero
      logic [15:0] opcode;
      logic [1:0]  opcode_bytes;
      // ModRM then SIB
      logic [15:0] addressing;
      logic [1:0]  addressing_bytes;
      logic [3:0]  displacement_bytes;
      logic [3:0]  immediate_bytes;
      // Displacement then immediate, left-aligned
      logic [63:0] displace_n_imm;
      logic [4:0]  length;
   } decoded_inst_t;

   // Per-opcode properties
   typedef struct packed {
      logic [1:0] opcode_bytes;
      logic       has_modrm;
      logic [3:0] imm_bytes;
      logic       is_halt;
   } op_class_t;

endpackage

/* source/decode_stage_0.sv */
// x86 decode stage 0 top level
// Length decode of one instruction per cycle from a 16-byte fetch window

`timescale 1ns/1ps

module decode_stage_0 #(
   parameter int ADDR_WIDTH = 32,
   parameter int PREFIX_MAX = 3
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      flush,
   input  logic                      handle_int,
   output logic                      halt,
   input  logic                      f_valid,
   output logic                      f_ready,
   input  decode_pkg::fetch_window_t f_window,
   input  logic [ADDR_WIDTH-1:0]     f_pc,
   input  logic                      f_branch_taken,
   output logic [5:0]                f_bytes_read,
   output logic                      s0_valid,
   input  logic                      s0_ready,
   output decode_pkg::decoded_inst_t s0_inst,
   output logic [ADDR_WIDTH-1:0]     s0_pc,
   output logic                      s0_branch_taken
);

   logic [1:0]                prefix_bytes;
   logic                      size_override;
   logic [15:0]               opcode_aligned;
   logic [15:0]               addressing_aligned;
   logic [1:0]                addressing_bytes;
   logic [3:0]                displacement_bytes;
   decode_pkg::op_class_t     op_class;
   decode_pkg::decoded_inst_t inst;

   // Length goes back to fetch every cycle
   assign f_bytes_read = {1'b0, inst.length};

   prefix_scan #(
      .PREFIX_MAX(PREFIX_MAX)
   ) u_prefix_scan (
      .window       (f_window.instruction[127:104]),
      .prefix_bytes (prefix_bytes),
      .size_override(size_override)
   );

   opcode_classify u_opcode_classify (
      .opcode       (opcode_aligned),
      .size_override(size_override),
      .op_class     (op_class)
   );

   modrm_sib_decode u_modrm_sib_decode (
      .addressing        (addressing_aligned),
      .has_modrm         (op_class.has_modrm),
      .addressing_bytes  (addressing_bytes),
      .displacement_bytes(displacement_bytes)
   );

   field_align u_field_align (
      .window            (f_window),
      .prefix_bytes      (prefix_bytes),
      .size_override     (size_override),
      .op_class          (op_class),
      .addressing_bytes  (addressing_bytes),
      .displacement_bytes(displacement_bytes),
      .opcode_aligned    (opcode_aligned),
      .addressing_aligned(addressing_aligned),
      .inst              (inst)
   );

   decode_control #(
      .ADDR_WIDTH(ADDR_WIDTH)
   ) u_decode_control (
      .clk            (clk),
      .rst_n          (rst_n),
      .flush          (flush),
      .handle_int     (handle_int),
      .halt           (halt),
      .f_valid        (f_valid),
      .f_ready        (f_ready),
      .valid_bytes    (f_window.valid_bytes),
      .inst_in        (inst),
      .is_halt        (op_class.is_halt),
      .f_pc           (f_pc),
      .f_branch_taken (f_branch_taken),
      .s0_valid       (s0_valid),
      .s0_ready       (s0_ready),
      .s0_inst        (s0_inst),
      .s0_pc          (s0_pc),
      .s0_branch_taken(s0_branch_taken)
   );

endmodule

/* source/field_align.sv */
// Field alignment and length sum
// Byte shifts the window to pull out opcode, ModRM/SIB and disp+imm fields

`timescale 1ns/1ps

module field_align (
   input  decode_pkg::fetch_window_t window,
   input  logic [1:0]                prefix_bytes,
   input  logic                      size_override,
   input  decode_pkg::op_class_t     op_class,
   input  logic [1:0]                addressing_bytes,
   input  logic [3:0]                displacement_bytes,
   output logic [15:0]               opcode_aligned,
   output logic [15:0]               addressing_aligned,
   output decode_pkg::decoded_inst_t inst
);

   function automatic logic [127:0] shift_bytes(input logic [127:0] data,
                                                input logic [2:0]   n);
      return data << {n, 3'b000};
   endfunction

   logic [2:0]   po_bytes;
   logic [2:0]   poa_bytes;
   logic [3:0]   field_bytes;
   logic [127:0] po_shift;
   logic [127:0] poa_shift;
   logic [127:0] op_shift;
   logic [63:0]  field_mask;

   // Running byte offsets
   assign po_bytes    = {1'b0, prefix_bytes} + {1'b0, op_class.opcode_bytes};
   assign poa_bytes   = po_bytes + {1'b0, addressing_bytes};
   assign field_bytes = displacement_bytes + op_class.imm_bytes;

   assign op_shift  = shift_bytes(window.instruction, {1'b0, prefix_bytes});
   assign po_shift  = shift_bytes(window.instruction, po_bytes);
   assign poa_shift = shift_bytes(window.instruction, poa_bytes);

   assign opcode_aligned     = op_shift[127:112];
   assign addressing_aligned = po_shift[127:112];

   // Keeps only displacement and immediate bytes
   assign field_mask = ~({64{1'b1}} >> {field_bytes, 3'b000});

   always_comb begin
      inst                    = '0;
      inst.prefix             = window.instruction[127:104];
      inst.prefix_bytes       = prefix_bytes;
      inst.size_override      = size_override;
      inst.opcode_bytes       = op_class.opcode_bytes;
      inst.opcode             = (op_class.opcode_bytes == 2'd2) ? opcode_aligned
                                                                : {opcode_aligned[15:8], 8'h00};
      inst.addressing_bytes   = addressing_bytes;
      case (addressing_bytes)
         2'd1:    inst.addressing = {addressing_aligned[15:8], 8'h00};
         2'd2:    inst.addressing = addressing_aligned;
         default: inst.addressing = 16'h0000;
      endcase
      inst.displacement_bytes = displacement_bytes;
      inst.immediate_bytes    = op_class.imm_bytes;
      inst.displace_n_imm     = poa_shift[127:64] & field_mask;
      inst.length             = {2'b00, poa_bytes} + {1'b0, field_bytes};
   end

   always_comb begin
      assert (inst.length <= 5'(decode_pkg::MAX_INST_LEN))
         else $error("field_align: length %0d exceeds limit", inst.length);
   end

endmodule

/* source/modrm_sib_decode.sv */
// ModRM and SIB decode, 32-bit addressing only
// Sizes the addressing bytes and the displacement

`timescale 1ns/1ps

module modrm_sib_decode (
   input  logic [15:0] addressing,
   input  logic        has_modrm,
   output logic [1:0]  addressing_bytes,
   output logic [3:0]  displacement_bytes
);

   logic [1:0] mod_f;
   logic [2:0] rm_f;
   logic [2:0] sib_base;
   logic       has_sib;

   assign mod_f    = addressing[15:14];
   assign rm_f     = addressing[10:8];
   assign sib_base = addressing[2:0];

   // rm 100 escapes to SIB in every memory form
   assign has_sib = (mod_f != 2'b11) && (rm_f == 3'b100);

   always_comb begin
      addressing_bytes   = 2'd0;
      displacement_bytes = 4'd0;
      if (has_modrm) begin
         addressing_bytes = has_sib ? 2'd2 : 2'd1;
         case (mod_f)
            2'b01: displacement_bytes = 4'd1;
            2'b10: displacement_bytes = 4'd4;
            2'b00: begin
               // disp32 with no base register
               if (rm_f == 3'b101 || (has_sib && sib_base == 3'b101)) begin
                  displacement_bytes = 4'd4;
               end
            end
            default: displacement_bytes = 4'd0;
         endcase
      end
   end

endmodule

/* source/opcode_classify.sv */
// Opcode classification for the supported subset
// Gives opcode length, ModRM presence, immediate size and HLT detect

`timescale 1ns/1ps

module opcode_classify (
   input  logic [15:0]           opcode,
   input  logic                  size_override,
   output decode_pkg::op_class_t op_class
);

   always_comb begin
      logic [7:0] b0;
      logic [7:0] b1;
      logic [3:0] imm32;
      b0    = opcode[15:8];
      b1    = opcode[7:0];
      // 0x66 turns a 32-bit immediate into 16 bits
      imm32 = size_override ? 4'd2 : 4'd4;

      op_class              = '0;
      op_class.opcode_bytes = 2'd1;

      if (b0 == decode_pkg::OPC_ESCAPE) begin
         op_class.opcode_bytes = 2'd2;
         // Jcc rel32
         if (b1[7:4] == 4'h8) begin
            op_class.imm_bytes = imm32;
         end else if (b1 == 8'hAF || b1 == 8'hB6 || b1 == 8'hB7) begin
            op_class.has_modrm = 1'b1;
         end
      end else if (b0[7:6] == 2'b00) begin
         // ALU block, low three bits pick the form
         case (b0[2:0])
            3'd0, 3'd1, 3'd2, 3'd3: op_class.has_modrm = 1'b1;
            3'd4:    op_class.imm_bytes = 4'd1;
            3'd5:    op_class.imm_bytes = imm32;
            default: op_class.imm_bytes = 4'd0;
         endcase
      end else begin
         case (b0) inside
            [8'h70:8'h7F], 8'hEB: begin
               op_class.imm_bytes = 4'd1;
            end
            8'h80, 8'h83: begin
               op_class.has_modrm = 1'b1;
               op_class.imm_bytes = 4'd1;
            end
            8'h81: begin
               op_class.has_modrm = 1'b1;
               op_class.imm_bytes = imm32;
            end
            [8'h88:8'h8B]: begin
               op_class.has_modrm = 1'b1;
            end
            [8'hB8:8'hBF], 8'hE8, 8'hE9: begin
               op_class.imm_bytes = imm32;
            end
            decode_pkg::OPC_HLT: begin
               op_class.is_halt = 1'b1;
            end
            default: begin
               op_class.imm_bytes = 4'd0;
            end
         endcase
      end
   end

endmodule

/* source/prefix_scan.sv */
// Legacy prefix scan
// Counts leading prefix bytes up to PREFIX_MAX and flags operand-size override

`timescale 1ns/1ps

module prefix_scan #(
   parameter int PREFIX_MAX = 3
) (
   input  logic [23:0] window,
   output logic [1:0]  prefix_bytes,
   output logic        size_override
);

   function automatic logic is_prefix(input logic [7:0] b);
      case (b)
         8'h66, 8'hF2, 8'hF3, 8'h26, 8'h2E, 8'h36, 8'h3E: is_prefix = 1'b1;
         default: is_prefix = 1'b0;
      endcase
   endfunction

   always_comb begin
      logic       in_run;
      logic [7:0] b;
      in_run        = 1'b1;
      b             = 8'h00;
      prefix_bytes  = 2'd0;
      size_override = 1'b0;
      // Run stops at the first non-prefix byte
      for (int i = 0; i < PREFIX_MAX; i++) begin
         b = window[23 - 8*i -: 8];
         if (in_run && is_prefix(b)) begin
            prefix_bytes = prefix_bytes + 2'd1;
            if (b == decode_pkg::PFX_OPSIZE) begin
               size_override = 1'b1;
            end
         end else begin
            in_run = 1'b0;
         end
      end
   end

endmodule

/* verification/decode_checker.sv */
// Decode stage 0 checker
// Reference length decode of each fetch offer and in-order compare of the s0 output

`timescale 1ns/1ps

module decode_checker #(
   parameter int ADDR_WIDTH = 32,
   parameter int PREFIX_MAX = 3
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      flush,
   input  logic                      f_valid,
   input  logic                      f_ready,
   input  decode_pkg::fetch_window_t f_window,
   input  logic [ADDR_WIDTH-1:0]     f_pc,
   input  logic                      f_branch_taken,
   input  logic [5:0]                f_bytes_read,
   input  logic                      s0_valid,
   input  logic                      s0_ready,
   input  decode_pkg::decoded_inst_t s0_inst,
   input  logic [ADDR_WIDTH-1:0]     s0_pc,
   input  logic                      s0_branch_taken,
   output int                        error_count,
   output int                        check_count,
   output int                        pending_count
);

   typedef struct packed {
      decode_pkg::decoded_inst_t inst;
      logic [ADDR_WIDTH-1:0]     pc;
      logic                      branch_taken;
   } expect_t;

   expect_t exp_q [$];

   function automatic logic is_legacy_prefix(input logic [7:0] b);
      return b == 8'h66 || b == 8'hF2 || b == 8'hF3 || b == 8'h26 ||
             b == 8'h2E || b == 8'h36 || b == 8'h3E;
   endfunction

   // Expected stage 0 record for one window, built byte by byte
   function automatic decode_pkg::decoded_inst_t ref_decode(input logic [127:0] instr,
                                                            input int         pmax);
      decode_pkg::decoded_inst_t r;
      logic [7:0]                b [16];
      logic [7:0]                op0;
      logic [7:0]                op1;
      logic [7:0]                m;
      logic                      has_m;
      logic                      sib;
      int                        p;
      int                        ob;
      int                        imm;
      int                        disp;
      int                        pos;
      r = '0;
      for (int i = 0; i < 16; i++) begin
         b[i] = instr[127 - 8*i -: 8];
      end
      r.prefix = instr[127:104];
      p = 0;
      while (p < pmax && is_legacy_prefix(b[p])) begin
         if (b[p] == 8'h66) begin
            r.size_override = 1'b1;
         end
         p++;
      end
      op0   = b[p];
      op1   = b[p + 1];
      ob    = 1;
      has_m = 1'b0;
      imm   = 0;
      disp  = 0;
      if (op0 == 8'h0F) begin
         ob    = 2;
         has_m = (op1 == 8'hAF || op1 == 8'hB6 || op1 == 8'hB7);
         if (op1 >= 8'h80 && op1 <= 8'h8F) begin
            imm = 4;
         end
      end else if (op0 <= 8'h3F) begin
         has_m = (op0[2:0] <= 3'd3);
         if (op0[2:0] == 3'd4) begin
            imm = 1;
         end else if (op0[2:0] == 3'd5) begin
            imm = 4;
         end
      end else if ((op0 >= 8'h70 && op0 <= 8'h7F) || op0 == 8'hEB) begin
         imm = 1;
      end else if (op0 == 8'h80 || op0 == 8'h83) begin
         has_m = 1'b1;
         imm   = 1;
      end else if (op0 == 8'h81) begin
         has_m = 1'b1;
         imm   = 4;
      end else if (op0 >= 8'h88 && op0 <= 8'h8B) begin
         has_m = 1'b1;
      end else if ((op0 >= 8'hB8 && op0 <= 8'hBF) || op0 == 8'hE8 || op0 == 8'hE9) begin
         imm = 4;
      end
      if (imm == 4 && r.size_override) begin
         imm = 2;
      end
      r.prefix_bytes = 2'(p);
      r.opcode_bytes = 2'(ob);
      r.opcode       = {op0, (ob == 2) ? op1 : 8'h00};
      pos            = p + ob;
      if (has_m) begin
         m   = b[pos];
         sib = (m[7:6] != 2'b11) && (m[2:0] == 3'b100);
         r.addressing_bytes = sib ? 2'd2 : 2'd1;
         r.addressing       = {m, sib ? b[pos + 1] : 8'h00};
         if (m[7:6] == 2'b01) begin
            disp = 1;
         end else if (m[7:6] == 2'b10) begin
            disp = 4;
         end else if (m[7:6] == 2'b00 &&
                      (m[2:0] == 3'b101 || (sib && b[pos + 1][2:0] == 3'b101))) begin
            disp = 4;
         end
         pos = pos + (sib ? 2 : 1);
      end
      r.displacement_bytes = 4'(disp);
      r.immediate_bytes    = 4'(imm);
      for (int k = 0; k < disp + imm; k++) begin
         r.displace_n_imm[63 - 8*k -: 8] = b[pos + k];
      end
      r.length = 5'(pos + disp + imm);
      return r;
   endfunction

   always @(posedge clk) begin
      decode_pkg::decoded_inst_t want;
      expect_t                   head;
      if (rst_n) begin
         // Output side first, the fetch side may refill the same edge
         if (s0_valid && s0_ready) begin
            if (exp_q.size() == 0) begin
               error_count++;
               $display("ERROR at %0t: s0 delivered an instruction nobody sent", $time);
            end else begin
               head = exp_q.pop_front();
               check_count++;
               if (s0_inst !== head.inst) begin
                  error_count++;
                  $display("MISMATCH t=%0t s0_inst got %h expected %h",
                           $time, s0_inst, head.inst);
               end
               if (s0_pc !== head.pc) begin
                  error_count++;
                  $display("MISMATCH t=%0t s0_pc got %h expected %h", $time, s0_pc, head.pc);
               end
               if (s0_branch_taken !== head.branch_taken) begin
                  error_count++;
                  $display("MISMATCH t=%0t s0_branch_taken got %b expected %b",
                           $time, s0_branch_taken, head.branch_taken);
               end
            end
         end else if (flush && s0_valid && exp_q.size() != 0) begin
            // Pending output is dropped by the flush
            head = exp_q.pop_front();
         end
         if (f_valid) begin
            want = ref_decode(f_window.instruction, PREFIX_MAX);
            check_count++;
            if (f_bytes_read !== {1'b0, want.length}) begin
               error_count++;
               $display("MISMATCH t=%0t f_bytes_read got %0d expected %0d",
                        $time, f_bytes_read, want.length);
            end
            if (f_ready) begin
               head.inst         = want;
               head.pc           = f_pc;
               head.branch_taken = f_branch_taken;
               exp_q.push_back(head);
            end
         end
         pending_count = exp_q.size();
      end
   end

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock and reset source
// 8 ns clock, synchronous active-low reset held for 8 cycles

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

   // Release lands just after an edge, like the rest of the stimulus
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

/* verification/tb_decode_stage_0.sv */
// Testbench for x86 decode stage 0
// Builds instructions from the supported subset and streams them through the DUT

`timescale 1ns/1ps

module tb_decode_stage_0;

   localparam int          ADDR_WIDTH   = 32;
   localparam int          PREFIX_MAX   = 3;
   localparam int          ACCEPT_LIMIT = 64;
   localparam int          DRAIN_LIMIT  = 64;
   localparam logic [31:0] SEED         = 32'hc15e_176d;

   // Opcode pools, none of them a prefix, an escape or HLT
   localparam logic [7:0] ONE_BYTE [16] = '{8'h00, 8'h03, 8'h04, 8'h05, 8'h2D, 8'h3C, 8'h07,
                                            8'h75, 8'hEB, 8'h80, 8'h81, 8'h83, 8'h8B, 8'hB9,
                                            8'hE8, 8'hC3};
   localparam logic [7:0] TWO_BYTE [8]  = '{8'h84, 8'h8F, 8'hAF, 8'hB6, 8'hB7, 8'h05, 8'hA2,
                                            8'h31};
   localparam logic [7:0] PREFIXES [8]  = '{8'hF2, 8'hF3, 8'h26, 8'h2E, 8'h36, 8'h3E, 8'hF3,
                                            8'h2E};

   logic                      clk;
   logic                      rst_n;
   logic                      flush;
   logic                      handle_int;
   logic                      halt;
   logic                      f_valid;
   logic                      f_ready;
   decode_pkg::fetch_window_t f_window;
   logic [ADDR_WIDTH-1:0]     f_pc;
   logic                      f_branch_taken;
   logic [5:0]                f_bytes_read;
   logic                      s0_valid;
   logic                      s0_ready;
   decode_pkg::decoded_inst_t s0_inst;
   logic [ADDR_WIDTH-1:0]     s0_pc;
   logic                      s0_branch_taken;

   int          error_count;
   int          check_count;
   int          pending_count;
   int          tb_errors;
   int          errors_before;
   int          test_num;
   int          tests_failed;
   int          ready_mode;
   logic [31:0] rng_state;
   logic [31:0] bp_state;
   logic [31:0] next_pc;
   logic [7:0]  win_bytes [16];
   int          win_len;

   tb_clock_gen u_clock_gen (
      .clk  (clk),
      .rst_n(rst_n)
   );

   decode_stage_0 #(
      .ADDR_WIDTH(ADDR_WIDTH),
      .PREFIX_MAX(PREFIX_MAX)
   ) u_decode_stage_0 (.*);

   decode_checker #(
      .ADDR_WIDTH(ADDR_WIDTH),
      .PREFIX_MAX(PREFIX_MAX)
   ) u_checker (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [7:0] rand_byte();
      rng_state = lcg_next(rng_state);
      return rng_state[23:16];
   endfunction

   // Mode 0 always ready, 1 random, 2 held low
   always @(posedge clk) begin
      #1;
      if (ready_mode == 1) begin
         bp_state = lcg_next(bp_state);
         s0_ready = bp_state[28];
      end else begin
         s0_ready = (ready_mode == 0);
      end
   end

   task automatic start_window();
      for (int i = 0; i < 16; i++) begin
         win_bytes[i] = rand_byte();
      end
      win_len = 0;
   endtask

   task automatic put_byte(input logic [7:0] b);
      win_bytes[win_len] = b;
      win_len++;
   endtask

   function automatic logic [127:0] pack_window();
      logic [127:0] w;
      w = '0;
      for (int i = 0; i < 16; i++) begin
         w[127 - 8*i -: 8] = win_bytes[i];
      end
      return w;
   endfunction

   // Prefix run, then a one or two byte opcode; later bytes stay random
   task automatic put_random_inst(input int n_pfx, input logic want_66);
      logic [7:0] r;
      int         pos66;
      r     = rand_byte();
      pos66 = (want_66 && n_pfx > 0) ? int'(r) % n_pfx : -1;
      for (int i = 0; i < n_pfx; i++) begin
         r = rand_byte();
         put_byte((i == pos66) ? decode_pkg::PFX_OPSIZE : PREFIXES[r[2:0]]);
      end
      r = rand_byte();
      if (r[7:6] == 2'b00) begin
         put_byte(decode_pkg::OPC_ESCAPE);
         put_byte(TWO_BYTE[r[2:0]]);
      end else begin
         put_byte(ONE_BYTE[r[3:0]]);
      end
   endtask

   task automatic report_timeout(input string what);
      $display("TIMEOUT at %0t: %s", $time, what);
      $display("FAIL: see errors above");
      $finish;
   endtask

   task automatic send_window(input logic [5:0] valid_count);
      logic [7:0] r;
      logic       accepted;
      int         waited;
      r                    = rand_byte();
      f_window.instruction = pack_window();
      f_window.valid_bytes = valid_count;
      f_pc                 = next_pc;
      f_branch_taken       = r[0];
      f_valid              = 1'b1;
      accepted             = 1'b0;
      waited               = 0;
      while (!accepted && waited < ACCEPT_LIMIT) begin
         @(posedge clk);
         accepted = f_ready;
         waited++;
      end
      #1;
      f_valid = 1'b0;
      next_pc = next_pc + 32'd16;
      if (!accepted) begin
         report_timeout("fetch did not accept the instruction");
      end
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (pending_count != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (pending_count != 0) begin
         report_timeout("decoded instructions never left the stage");
      end
   endtask

   task automatic set_ready_mode(input int mode);
      ready_mode = mode;
      repeat (2) @(posedge clk);
      #1;
   endtask

   task automatic end_test(input string name);
      int errs;
      errs = error_count + tb_errors - errors_before;
      test_num++;
      if (errs == 0) begin
         $display("test %0d %s: ok", test_num, name);
      end else begin
         $display("test %0d %s: %0d errors", test_num, name, errs);
         tests_failed++;
      end
      errors_before = error_count + tb_errors;
   endtask

   initial begin
      logic [7:0] r;
      int         n;
      rng_state      = SEED;
      bp_state       = lcg_next(SEED);
      next_pc        = 32'h0000_1000;
      ready_mode     = 0;
      flush          = 1'b0;
      handle_int     = 1'b0;
      f_valid        = 1'b0;
      f_window       = '0;
      f_pc           = '0;
      f_branch_taken = 1'b0;
      s0_ready       = 1'b1;

      n = 0;
      while (!rst_n && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (!rst_n) begin
         report_timeout("reset was never released");
      end
      #1;

      for (int i = 0; i < 40; i++) begin
         start_window();
         put_random_inst(0, 1'b0);
         send_window(6'd16);
      end
      drain();
      end_test("opcodes without prefixes");

      // Four prefixes go past the scan limit
      for (int i = 0; i < 40; i++) begin
         start_window();
         put_random_inst(i % 5, i[1]);
         send_window(6'd16);
      end
      drain();
      end_test("prefix runs");

      // Second pass forces SIB base 101 and adds an imm32
      for (int m = 0; m < 32; m++) begin
         for (int sb = 0; sb < 2; sb++) begin
            start_window();
            put_byte((sb == 1) ? 8'h81 : 8'h8B);
            put_byte({m[4:3], 3'b010, m[2:0]});
            r = rand_byte();
            put_byte({r[7:3], (sb == 1) ? 3'b101 : r[2:0]});
            send_window(6'd16);
         end
      end
      drain();
      end_test("modrm and sib forms");

      // 81 /0 with disp32 and imm32 is ten bytes long
      start_window();
      put_byte(8'h81);
      put_byte(8'b10_000_001);
      f_window.instruction = pack_window();
      f_window.valid_bytes = 6'd9;
      f_valid              = 1'b1;
      repeat (5) begin
         @(posedge clk);
         #1;
         if (f_ready || s0_valid) begin
            tb_errors++;
            $display("ERROR at %0t: short window was accepted", $time);
         end
      end
      send_window(6'd16);
      drain();
      end_test("short window");

      set_ready_mode(1);
      for (int i = 0; i < 300; i++) begin
         r = rand_byte();
         start_window();
         put_random_inst(int'(r[1:0]), r[2]);
         send_window(6'd16);
      end
      set_ready_mode(0);
      drain();
      end_test("random back-pressure");

      start_window();
      put_byte(decode_pkg::OPC_HLT);
      send_window(6'd16);
      n = 0;
      while (!halt && n < 16) begin
         @(posedge clk);
         #1;
         n++;
      end
      if (!halt) begin
         report_timeout("halt never rose after HLT");
      end
      start_window();
      put_byte(8'h90);
      f_window.instruction = pack_window();
      f_window.valid_bytes = 6'd16;
      f_valid              = 1'b1;
      repeat (4) begin
         @(posedge clk);
         #1;
         if (f_ready || !halt) begin
            tb_errors++;
            $display("ERROR at %0t: fetch was open while halted", $time);
         end
      end
      handle_int = 1'b1;
      @(posedge clk);
      #1;
      handle_int = 1'b0;
      send_window(6'd16);
      drain();

      // Output held back, then thrown away by flush
      set_ready_mode(2);
      start_window();
      put_random_inst(0, 1'b0);
      send_window(6'd16);
      if (!s0_valid) begin
         tb_errors++;
         $display("ERROR at %0t: no output pending before the flush", $time);
      end
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
      if (s0_valid) begin
         tb_errors++;
         $display("ERROR at %0t: output still valid after the flush", $time);
      end
      set_ready_mode(0);
      drain();
      end_test("halt, interrupt and flush");

      n = error_count + tb_errors;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_num, tests_failed, check_count, n);
      if (n == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
